// File: leaf_cfg.svh
`ifndef LEAF_CFG_SVH
`define LEAF_CFG_SVH

// Network packet and user word widths
`define PACKET_BITS 49
`define PAYLOAD_BITS 32

// Kernel port counts, ports are numbered from 1
`define NUM_IN_PORTS 3
`define NUM_OUT_PORTS 2

// Words per input buffer
`define FIFO_DEPTH 4

// Address of this leaf in the tree
`define LEAF_ID 5

`endif

// File: bft_pkg.sv
`include "leaf_cfg.svh"

package bft_pkg;

    // Data packet as it travels through the tree
    typedef struct packed {
        logic                     vld;
        logic [4:0]               dst_leaf;
        logic [3:0]               dst_port;
        logic [4:0]               src_leaf;
        logic [1:0]               src_port;
        logic [`PAYLOAD_BITS-1:0] payload;
    } bft_data_t;

    // Configuration packet, dst_port is zero
    typedef struct packed {
        logic                    vld;
        logic [4:0]              dst_leaf;
        logic [3:0]              dst_port;
        logic [3:0]              cfg_out_port;
        logic [4:0]              cfg_dest_leaf;
        logic [3:0]              cfg_dest_port;
        logic [`PACKET_BITS-24:0] reserved;
    } bft_cfg_t;

    // One packet word, read in either view
    typedef union packed {
        bft_data_t data;
        bft_cfg_t  cfg;
    } bft_packet_u;

endpackage

// File: leaf_pkg.sv
`include "leaf_cfg.svh"

package leaf_pkg;

    // Word on a kernel port with its valid flag
    typedef struct packed {
        logic [`PAYLOAD_BITS-1:0] data;
        logic                     vld;
    } user_word_t;

    // Where packets from one output port are sent
    typedef struct packed {
        logic       valid;
        logic [4:0] dest_leaf;
        logic [3:0] dest_port;
    } route_entry_t;

endpackage

// File: leaf_ctrl.sv
`timescale 1ns/1ps
`include "leaf_cfg.svh"

module leaf_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   ap_start,
    input  logic                   resend,
    input  bft_pkg::bft_cfg_t      cfg_pkt,
    output logic                   user_reset,
    output logic                   hold_out,
    output leaf_pkg::route_entry_t route [1:`NUM_OUT_PORTS]
);

    logic       started;
    logic [1:0] resend_tail;

    // Kernel leaves reset one cycle after ap_start is seen
    always_ff @(posedge clk) begin
        if (reset) begin
            started    <= 1'b0;
            user_reset <= 1'b1;
        end else begin
            if (ap_start) begin
                started <= 1'b1;
            end
            if (started) begin
                user_reset <= 1'b0;
            end
        end
    end

    // Last two cycles of resend, keeps egress quiet a little longer
    always_ff @(posedge clk) begin
        if (reset) begin
            resend_tail <= 2'b00;
        end else begin
            resend_tail <= {resend_tail[0], resend};
        end
    end

    assign hold_out = resend || (resend_tail != 2'b00);

    // Route table, writes to unknown output ports fall through
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int p = 1; p <= `NUM_OUT_PORTS; p++) begin
                route[p] <= '0;
            end
        end else begin
            for (int p = 1; p <= `NUM_OUT_PORTS; p++) begin
                if (cfg_pkt.vld && (cfg_pkt.cfg_out_port == 4'(p))) begin
                    route[p].valid     <= 1'b1;
                    route[p].dest_leaf <= cfg_pkt.cfg_dest_leaf;
                    route[p].dest_port <= cfg_pkt.cfg_dest_port;
                end
            end
        end
    end

    // Ingress must not deliver configuration while the leaf is in reset
    cfg_quiet_in_reset: assert property (@(posedge clk) reset |=> !cfg_pkt.vld)
        else $error("configuration write seen before reset release");

endmodule

// File: leaf_ingress.sv
`timescale 1ns/1ps
`include "leaf_cfg.svh"

module leaf_ingress (
    input  logic                 clk,
    input  logic                 reset,
    input  bft_pkg::bft_packet_u din,
    output bft_pkg::bft_cfg_t    cfg_pkt,
    output leaf_pkg::user_word_t user_in [1:`NUM_IN_PORTS],
    input  logic                 user_in_ack [1:`NUM_IN_PORTS]
);

    localparam int PTR_BITS = $clog2(`FIFO_DEPTH);
    localparam int CNT_BITS = $clog2(`FIFO_DEPTH + 1);

    logic                     for_me;
    logic                     is_cfg;
    logic [`NUM_IN_PORTS:1]   wr_req;
    logic [`NUM_IN_PORTS:1]   wr_en;
    logic [`NUM_IN_PORTS:1]   rd_en;
    logic [`NUM_IN_PORTS:1]   full;

    logic [`PAYLOAD_BITS-1:0] mem [1:`NUM_IN_PORTS][0:`FIFO_DEPTH-1];
    logic [PTR_BITS-1:0]      wr_ptr [1:`NUM_IN_PORTS];
    logic [PTR_BITS-1:0]      rd_ptr [1:`NUM_IN_PORTS];
    logic [CNT_BITS-1:0]      count [1:`NUM_IN_PORTS];

    assign for_me = din.data.vld && (din.data.dst_leaf == 5'(`LEAF_ID));
    assign is_cfg = for_me && (din.data.dst_port == 4'd0);

    // Port decode, ports above NUM_IN_PORTS match nothing
    always_comb begin
        for (int p = 1; p <= `NUM_IN_PORTS; p++) begin
            full[p]         = (count[p] == CNT_BITS'(`FIFO_DEPTH));
            wr_req[p]       = for_me && (din.data.dst_port == 4'(p));
            wr_en[p]        = wr_req[p] && !full[p];
            rd_en[p]        = user_in_ack[p] && (count[p] != '0);
            user_in[p].vld  = (count[p] != '0);
            user_in[p].data = mem[p][rd_ptr[p]];
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 1; p <= `NUM_IN_PORTS; p++) begin
            if (wr_en[p]) begin
                mem[p][wr_ptr[p]] <= din.data.payload;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int p = 1; p <= `NUM_IN_PORTS; p++) begin
                wr_ptr[p] <= '0;
                rd_ptr[p] <= '0;
                count[p]  <= '0;
            end
        end else begin
            for (int p = 1; p <= `NUM_IN_PORTS; p++) begin
                if (wr_en[p]) begin
                    wr_ptr[p] <= (wr_ptr[p] == PTR_BITS'(`FIFO_DEPTH - 1)) ? '0
                                                                        : wr_ptr[p] + 1'b1;
                end
                if (rd_en[p]) begin
                    rd_ptr[p] <= (rd_ptr[p] == PTR_BITS'(`FIFO_DEPTH - 1)) ? '0
                                                                        : rd_ptr[p] + 1'b1;
                end
                case ({wr_en[p], rd_en[p]})
                    2'b10:   count[p] <= count[p] + 1'b1;
                    2'b01:   count[p] <= count[p] - 1'b1;
                    default: count[p] <= count[p];
                endcase
            end
        end
    end

    // Configuration goes to the route table one cycle later
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg_pkt <= '0;
        end else begin
            cfg_pkt <= is_cfg ? din.cfg : '0;
        end
    end

    // Tree has no back-pressure, so a packet for a full buffer is lost
    no_write_when_full: assert property (@(posedge clk) disable iff (reset)
        (wr_req & full) == '0)
        else $error("input buffer full, packet dropped");

endmodule

// File: leaf_egress.sv
`timescale 1ns/1ps
`include "leaf_cfg.svh"

module leaf_egress (
    input  logic                   clk,
    input  logic                   reset,
    input  leaf_pkg::user_word_t   user_out [1:`NUM_OUT_PORTS],
    output logic                   user_out_ack [1:`NUM_OUT_PORTS],
    input  leaf_pkg::route_entry_t route [1:`NUM_OUT_PORTS],
    input  logic                   hold_out,
    output bft_pkg::bft_packet_u   dout
);
    import bft_pkg::*;

    logic [`NUM_OUT_PORTS:1] req;
    logic [`NUM_OUT_PORTS:1] ack_vec;
    logic [1:0]              last_port;
    logic [1:0]              grant_port;
    logic                    grant_any;
    bft_packet_u             pkt;
    bft_packet_u             dout_q;

    always_comb begin
        for (int p = 1; p <= `NUM_OUT_PORTS; p++) begin
            req[p] = user_out[p].vld && route[p].valid && !hold_out;
        end
    end

    // Round-robin, search starts just after the last granted port
    always_comb begin
        int cand;
        grant_any  = 1'b0;
        grant_port = '0;
        for (int k = 1; k <= `NUM_OUT_PORTS; k++) begin
            cand = ((int'(last_port) + k - 1) % `NUM_OUT_PORTS) + 1;
            if (!grant_any && req[cand]) begin
                grant_any  = 1'b1;
                grant_port = 2'(cand);
            end
        end
    end

    always_comb begin
        for (int p = 1; p <= `NUM_OUT_PORTS; p++) begin
            ack_vec[p]      = grant_any && (grant_port == 2'(p));
            user_out_ack[p] = ack_vec[p];
        end
    end

    // Packet for the granted port, all zero when nothing is granted
    always_comb begin
        pkt = '0;
        for (int p = 1; p <= `NUM_OUT_PORTS; p++) begin
            if (ack_vec[p]) begin
                pkt.data.vld      = 1'b1;
                pkt.data.dst_leaf = route[p].dest_leaf;
                pkt.data.dst_port = route[p].dest_port;
                pkt.data.src_leaf = 5'(`LEAF_ID);
                pkt.data.src_port = 2'(p);
                pkt.data.payload  = user_out[p].data;
            end
        end
    end

    // A packet caught by hold_out waits here until the hold ends
    always_ff @(posedge clk) begin
        if (reset) begin
            dout_q    <= '0;
            last_port <= 2'(`NUM_OUT_PORTS);
        end else if (!hold_out) begin
            dout_q <= pkt;
            if (grant_any) begin
                last_port <= grant_port;
            end
        end
    end

    assign dout = hold_out ? '0 : dout_q;

    one_grant: assert property (@(posedge clk) disable iff (reset) $onehot0(ack_vec))
        else $error("more than one output port acked");

endmodule

// File: user_kernel.sv
`timescale 1ns/1ps
`include "leaf_cfg.svh"

module user_kernel (
    input  logic                 clk,
    input  logic                 reset,
    input  leaf_pkg::user_word_t user_in [1:`NUM_IN_PORTS],
    output logic                 user_in_ack [1:`NUM_IN_PORTS],
    output leaf_pkg::user_word_t user_out [1:`NUM_OUT_PORTS],
    input  logic                 user_out_ack [1:`NUM_OUT_PORTS]
);

    logic                     running;
    logic [`NUM_OUT_PORTS:1]  out_free;
    logic [`NUM_OUT_PORTS:1]  load;
    logic [`NUM_OUT_PORTS:1]  out_vld;
    logic [`PAYLOAD_BITS-1:0] out_data [1:`NUM_OUT_PORTS];
    logic [`PAYLOAD_BITS-1:0] result [1:`NUM_OUT_PORTS];

    // No acks until the first cycle out of reset
    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    // Output register can take a new word in the cycle it is drained
    always_comb begin
        for (int p = 1; p <= `NUM_OUT_PORTS; p++) begin
            out_free[p] = !out_vld[p] || user_out_ack[p];
        end
    end

    // Sum needs both operands present at once
    assign load[1] = running && user_in[1].vld && user_in[2].vld && out_free[1];
    assign load[2] = running && user_in[3].vld && out_free[2];

    assign result[1] = user_in[1].data + user_in[2].data;
    assign result[2] = {user_in[3].data[`PAYLOAD_BITS-2:0], user_in[3].data[`PAYLOAD_BITS-1]};

    assign user_in_ack[1] = load[1];
    assign user_in_ack[2] = load[1];
    assign user_in_ack[3] = load[2];

    always_ff @(posedge clk) begin
        if (reset) begin
            out_vld <= '0;
        end else begin
            for (int p = 1; p <= `NUM_OUT_PORTS; p++) begin
                if (load[p]) begin
                    out_vld[p] <= 1'b1;
                end else if (user_out_ack[p]) begin
                    out_vld[p] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 1; p <= `NUM_OUT_PORTS; p++) begin
            if (load[p]) begin
                out_data[p] <= result[p];
            end
        end
    end

    always_comb begin
        for (int p = 1; p <= `NUM_OUT_PORTS; p++) begin
            user_out[p].vld  = out_vld[p];
            user_out[p].data = out_data[p];
        end
    end

endmodule

// File: leaf_top.sv
`timescale 1ns/1ps
`include "leaf_cfg.svh"

module leaf_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 ap_start,
    input  logic                 resend,
    input  bft_pkg::bft_packet_u din,
    output bft_pkg::bft_packet_u dout
);
    import bft_pkg::*;
    import leaf_pkg::*;

    bft_cfg_t     cfg_pkt;
    logic         user_reset;
    logic         hold_out;
    route_entry_t route [1:`NUM_OUT_PORTS];
    user_word_t   user_in [1:`NUM_IN_PORTS];
    logic         user_in_ack [1:`NUM_IN_PORTS];
    user_word_t   user_out [1:`NUM_OUT_PORTS];
    logic         user_out_ack [1:`NUM_OUT_PORTS];

    leaf_ctrl i_leaf_ctrl (
        .clk        (clk),
        .reset      (reset),
        .ap_start   (ap_start),
        .resend     (resend),
        .cfg_pkt    (cfg_pkt),
        .user_reset (user_reset),
        .hold_out   (hold_out),
        .route      (route)
    );

    leaf_ingress i_leaf_ingress (
        .clk         (clk),
        .reset       (reset),
        .din         (din),
        .cfg_pkt     (cfg_pkt),
        .user_in     (user_in),
        .user_in_ack (user_in_ack)
    );

    // Kernel runs on the leaf clock, held by its own reset
    user_kernel i_user_kernel (
        .clk          (clk),
        .reset        (user_reset),
        .user_in      (user_in),
        .user_in_ack  (user_in_ack),
        .user_out     (user_out),
        .user_out_ack (user_out_ack)
    );

    leaf_egress i_leaf_egress (
        .clk          (clk),
        .reset        (reset),
        .user_out     (user_out),
        .user_out_ack (user_out_ack),
        .route        (route),
        .hold_out     (hold_out),
        .dout         (dout)
    );

endmodule

// File: tb_leaf.sv
`timescale 1ns/1ps
`include "leaf_cfg.svh"

module tb_leaf;
    import bft_pkg::*;
    import leaf_pkg::*;

    logic         clk = 1'b0;
    logic         reset;
    logic         ap_start;
    logic         resend;
    bft_packet_u  din;
    bft_packet_u  dout;

    logic [31:0]  lfsr = 32'h4ad2;
    route_entry_t route_model [1:`NUM_OUT_PORTS];
    bft_packet_u  exp_q1 [$];
    bft_packet_u  exp_q2 [$];
    bft_packet_u  exp_pkt;
    logic [31:0]  pre_a [0:1];
    logic [31:0]  pre_b [0:1];
    logic [31:0]  pre_r [0:1];
    int           check_errors = 0;
    int           seq_errors = 0;
    int           missing = 0;
    int           pkts_sent = 0;
    int           pkts_seen = 0;
    int           seen_before = 0;
    int           cycles = 0;

    leaf_top i_leaf_top (
        .clk      (clk),
        .reset    (reset),
        .ap_start (ap_start),
        .resend   (resend),
        .din      (din),
        .dout     (dout)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // One LFSR step per bit of the word
    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            w = {w[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return w;
    endfunction

    // Output 1 carries a plus b and output 2 carries a rotated left by one
    function automatic bft_packet_u expected_packet(int src, logic [31:0] a, logic [31:0] b);
        bft_packet_u p;
        p = '0;
        p.data.vld      = 1'b1;
        p.data.dst_leaf = route_model[src].dest_leaf;
        p.data.dst_port = route_model[src].dest_port;
        p.data.src_leaf = 5'(`LEAF_ID);
        p.data.src_port = 2'(src);
        p.data.payload  = (src == 1) ? a + b : {a[30:0], a[31]};
        return p;
    endfunction

    // One packet followed by one idle cycle
    task automatic send_packet(bft_packet_u p);
        @(posedge clk);
        din <= p;
        @(posedge clk);
        din <= '0;
        pkts_sent++;
    endtask

    task automatic send_data(logic [4:0] leaf, logic [3:0] port, logic [31:0] payload);
        bft_packet_u p;
        p = '0;
        p.data.vld      = 1'b1;
        p.data.dst_leaf = leaf;
        p.data.dst_port = port;
        p.data.src_leaf = 5'd1;
        p.data.payload  = payload;
        send_packet(p);
    endtask

    task automatic write_route(logic [3:0] out_port, logic [4:0] leaf, logic [3:0] port);
        bft_packet_u p;
        p = '0;
        p.cfg.vld           = 1'b1;
        p.cfg.dst_leaf      = 5'(`LEAF_ID);
        p.cfg.cfg_out_port  = out_port;
        p.cfg.cfg_dest_leaf = leaf;
        p.cfg.cfg_dest_port = port;
        send_packet(p);
        if (out_port >= 4'd1 && out_port <= 4'(`NUM_OUT_PORTS)) begin
            route_model[int'(out_port)].valid     = 1'b1;
            route_model[int'(out_port)].dest_leaf = leaf;
            route_model[int'(out_port)].dest_port = port;
        end
    endtask

    task automatic send_sum(logic [31:0] a, logic [31:0] b);
        exp_q1.push_back(expected_packet(1, a, b));
        send_data(5'(`LEAF_ID), 4'd1, a);
        send_data(5'(`LEAF_ID), 4'd2, b);
    endtask

    task automatic send_rot(logic [31:0] a);
        exp_q2.push_back(expected_packet(2, a, 32'h0));
        send_data(5'(`LEAF_ID), 4'd3, a);
    endtask

    task automatic wait_drain();
        while (exp_q1.size() != 0 || exp_q2.size() != 0) begin
            @(posedge clk);
        end
        repeat (5) @(posedge clk);
    endtask

    // Checks dout against the expected queue of its source port
    always @(negedge clk) begin
        if (!reset) begin
            if (resend) begin
                assert (dout == '0) else begin
                    check_errors++;
                    $display("ERR %0t: dout %h during resend", $time, dout);
                end
            end
            if (dout.data.vld) begin
                pkts_seen++;
                exp_pkt = '0;
                if (dout.data.src_port == 2'd1 && exp_q1.size() != 0) begin
                    exp_pkt = exp_q1.pop_front();
                end else if (dout.data.src_port == 2'd2 && exp_q2.size() != 0) begin
                    exp_pkt = exp_q2.pop_front();
                end
                if (exp_pkt.data.vld) begin
                    assert (dout == exp_pkt) else begin
                        check_errors++;
                        $display("ERR %0t: got %h, expected %h", $time, dout, exp_pkt);
                    end
                end else begin
                    check_errors++;
                    $display("Packet %h left the leaf with nothing expected from its port", dout);
                end
            end else begin
                assert (dout == '0) else begin
                    check_errors++;
                    $display("ERR %0t: idle dout is %h, not zero", $time, dout);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > 100 * pkts_sent + 1000) begin
            $display("Run stopped after %0d cycles, %0d expected packets never came out",
                     cycles, exp_q1.size() + exp_q2.size());
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        reset    = 1'b1;
        ap_start = 1'b0;
        resend   = 1'b0;
        din      = '0;
        for (int p = 1; p <= `NUM_OUT_PORTS; p++) begin
            route_model[p] = '0;
        end
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // Kernel still in reset and no routes yet
        for (int i = 0; i < 2; i++) begin
            pre_a[i] = rand_word();
            pre_b[i] = rand_word();
            pre_r[i] = rand_word();
            send_data(5'(`LEAF_ID), 4'd1, pre_a[i]);
            send_data(5'(`LEAF_ID), 4'd2, pre_b[i]);
            send_data(5'(`LEAF_ID), 4'd3, pre_r[i]);
        end
        repeat (40) @(posedge clk);
        write_route(4'd1, 5'd12, 4'd3);
        write_route(4'd2, 5'd20, 4'd7);
        repeat (20) @(posedge clk);
        assert (pkts_seen == 0) else begin
            seq_errors++;
            $display("ERR %0t: %0d packets out before ap_start", $time, pkts_seen);
        end
        for (int i = 0; i < 2; i++) begin
            exp_q1.push_back(expected_packet(1, pre_a[i], pre_b[i]));
            exp_q2.push_back(expected_packet(2, pre_r[i], 32'h0));
        end
        @(posedge clk);
        ap_start <= 1'b1;
        @(posedge clk);
        ap_start <= 1'b0;
        wait_drain();

        // Carry out of bit 31 is dropped
        send_sum(32'hffff_fff0, 32'h0000_0031);
        for (int i = 0; i < 6; i++) begin
            send_sum(rand_word(), rand_word());
            send_rot(rand_word());
        end
        wait_drain();

        // Foreign leaf, bad ports and a write to a missing output port
        seen_before = pkts_seen;
        send_data(5'd4, 4'd1, rand_word());
        send_data(5'd6, 4'd3, rand_word());
        send_data(5'(`LEAF_ID), 4'd5, rand_word());
        send_data(5'(`LEAF_ID), 4'd15, rand_word());
        write_route(4'd3, 5'd1, 4'd1);
        repeat (30) @(posedge clk);
        assert (pkts_seen == seen_before) else begin
            seq_errors++;
            $display("ERR %0t: filtered packets produced %0d outputs", $time,
                     pkts_seen - seen_before);
        end
        send_sum(rand_word(), rand_word());
        wait_drain();

        // Traffic in flight when resend rises
        send_sum(rand_word(), rand_word());
        send_rot(rand_word());
        resend <= 1'b1;
        send_sum(rand_word(), rand_word());
        send_rot(rand_word());
        send_rot(rand_word());
        repeat (10) @(posedge clk);
        resend <= 1'b0;
        wait_drain();

        write_route(4'd1, 5'd9, 4'd2);
        repeat (4) @(posedge clk);
        for (int i = 0; i < 4; i++) begin
            send_sum(rand_word(), rand_word());
            send_rot(rand_word());
        end
        wait_drain();

        missing = exp_q1.size() + exp_q2.size();
        if (missing != 0) begin
            $display("%0d expected packets never came out of the leaf", missing);
        end
        $display("Errors: %0d on dout, %0d in sequence checks, %0d packets missing",
                 check_errors, seq_errors, missing);
        if (check_errors == 0 && seq_errors == 0 && missing == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+.
bft_pkg.sv
leaf_pkg.sv
leaf_ctrl.sv
leaf_ingress.sv
leaf_egress.sv
user_kernel.sv
leaf_top.sv
tb_leaf.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_leaf -f all.f -o tb_leaf_sim

sim_output=$(./obj_dir/tb_leaf_sim)
echo "$sim_output"

if echo "$sim_output" | grep -qx "Everything OK"; then
    exit 0
else
    exit 1
fi
